// ==== project.f ====
design/lsq_pkg.sv
design/mem_decode.sv
design/agu.sv
design/memory_queue.sv
design/data_ram.sv
design/mem_result.sv
design/lsu_top.sv
sim/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# build and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_lsu -f project.f -o tb_lsu_sim \
    && ./obj_dir/tb_lsu_sim \
    || exit 1

// ==== sim/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;

    localparam int QUEUE_DEPTH  = 16;
    localparam int MEM_WORDS    = 256;
    localparam int N_OPS        = 2 + 18 + 4 + QUEUE_DEPTH + 300;
    localparam int LIMIT_CYCLES = 20 * N_OPS + 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               dispatch_valid;
    lsq_pkg::dispatch_t dispatch;
    logic               commit_valid = 1'b0;
    logic [5:0]         commit_rob = '0;
    logic               full;
    lsq_pkg::cdb_t      cdb;

    lsq_pkg::cdb_t exp_q [$];     // expected results in program order
    logic [5:0]    rob_q [$];
    int            disp_q [$];    // dispatch cycle per rob entry
    logic [31:0]   ref_mem [MEM_WORDS];
    int            seed = 31;
    int            cycle = 0;
    int            issued = 0;
    int            retired = 0;
    logic [5:0]    next_rob = '0;
    logic          commit_en = 1'b1;

    lsu_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .MEM_WORDS(MEM_WORDS)) i_dut (
        .clk, .rst, .dispatch_valid, .dispatch, .commit_valid, .commit_rob, .full, .cdb
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] make_load(input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [11:0] imm);
        return {imm, 5'd1, f3, rd, lsq_pkg::op_load};
    endfunction

    function automatic logic [31:0] make_store(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], lsq_pkg::op_store};
    endfunction

    // bus record for one instruction against the memory image before it
    function automatic lsq_pkg::cdb_t expect_cdb(input lsq_pkg::dispatch_t d);
        lsq_pkg::cdb_t e;
        logic [31:0]   imm;
        logic [31:0]   addr;
        logic [31:0]   word;
        logic [31:0]   lanes;
        logic [3:0]    m;
        logic [1:0]    lane;
        logic          ld;
        ld   = (d.inst[6:0] == lsq_pkg::op_load);
        imm  = ld ? {{20{d.inst[31]}}, d.inst[31:20]}
                  : {{20{d.inst[31]}}, d.inst[31:25], d.inst[11:7]};
        addr = d.rs1_rdata + imm;
        lane = addr[1:0];
        word = ref_mem[addr[9:2]] >> (8 * lane);   // addressed lane moved to bit 0
        case (d.inst[13:12])
            2'b00:   m = 4'b0001 << lane;
            2'b01:   m = 4'b0011 << lane;
            default: m = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            lanes[8*b +: 8] = {8{m[b]}};
        end
        e         = '0;
        e.valid   = 1'b1;
        e.rob_idx = d.rob_num;
        e.pd_s    = d.pd_s;
        e.addr    = {addr[31:2], 2'b00};
        if (ld) begin
            e.rd_s  = d.inst[11:7];
            e.rmask = m;
            case (d.inst[14:12])
                lsq_pkg::f3_b:  e.rd_v = {{24{word[7]}}, word[7:0]};
                lsq_pkg::f3_bu: e.rd_v = {24'd0, word[7:0]};
                lsq_pkg::f3_h:  e.rd_v = {{16{word[15]}}, word[15:0]};
                lsq_pkg::f3_hu: e.rd_v = {16'd0, word[15:0]};
                default:        e.rd_v = word;
            endcase
        end else begin
            e.wmask = m;
            case (d.inst[13:12])
                2'b00:   e.wdata = {4{d.rs2_rdata[7:0]}} & lanes;
                2'b01:   e.wdata = {2{d.rs2_rdata[15:0]}} & lanes;
                default: e.wdata = d.rs2_rdata;
            endcase
        end
        return e;
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_cdb(input lsq_pkg::cdb_t got, input lsq_pkg::cdb_t want);
        if (got !== want) begin
            $display("ERROR @ %0t: cdb mismatch, got rob %0d pd %0d rd %0d rd_v %h", $time,
                     got.rob_idx, got.pd_s, got.rd_s, got.rd_v);
            $display("    got  addr %h rmask %b wmask %b wdata %h",
                     got.addr, got.rmask, got.wmask, got.wdata);
            $display("    want rob %0d pd %0d rd %0d rd_v %h addr %h rmask %b wmask %b wdata %h",
                     want.rob_idx, want.pd_s, want.rd_s, want.rd_v, want.addr, want.rmask,
                     want.wmask, want.wdata);
            stop_run();
        end
    endtask

    task automatic check_full(input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR @ %0t: full is %b, expected %b", $time, got, want);
            stop_run();
        end
    endtask

    // waits for a free slot and drives one instruction for a single cycle
    task automatic issue_op(input logic [31:0] inst, input logic [31:0] rs1,
                            input logic [31:0] rs2);
        lsq_pkg::dispatch_t d;
        @(negedge clk);
        while (issued - retired >= QUEUE_DEPTH) begin
            @(posedge clk);
            dispatch_valid <= 1'b0;
            @(negedge clk);
        end
        d.inst      = inst;
        d.rs1_rdata = rs1;
        d.rs2_rdata = rs2;
        d.pd_s      = 6'($random(seed));
        d.rob_num   = next_rob;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        next_rob = next_rob + 6'd1;
        issued   = issued + 1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            dispatch_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle_cycles(1);
        while (retired != issued) @(negedge clk);
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] rs2;
        logic [31:0] addr;
        logic [31:0] rs1;
        logic [11:0] imm;
        logic [2:0]  f3;
        r   = $random(seed);
        rs2 = $random(seed);
        imm = r[22:11];
        if (r[0]) begin
            case (r[3:1])
                3'd0:    f3 = lsq_pkg::f3_b;
                3'd1:    f3 = lsq_pkg::f3_bu;
                3'd2:    f3 = lsq_pkg::f3_h;
                3'd3:    f3 = lsq_pkg::f3_hu;
                default: f3 = lsq_pkg::f3_w;
            endcase
        end else begin
            case (r[2:1])
                2'd0:    f3 = lsq_pkg::f3_b;
                2'd1:    f3 = lsq_pkg::f3_h;
                default: f3 = lsq_pkg::f3_w;
            endcase
        end
        addr = {25'd0, r[8:4], 2'b00};   // 32-word window
        if (f3[1:0] == 2'b00) begin
            addr[1:0] = r[10:9];
        end else if (f3[1:0] == 2'b01) begin
            addr[1] = r[9];
        end
        rs1 = addr - {{20{imm[11]}}, imm};
        if (r[0]) begin
            issue_op(make_load(f3, r[27:23], imm), rs1, rs2);
        end else begin
            issue_op(make_store(f3, imm), rs1, rs2);
        end
        idle_cycles(int'(r[31:30]));
    endtask

    // stands in for the rob and checks each result in order
    always @(posedge clk) begin : rob_and_compare
        lsq_pkg::cdb_t want;
        cycle = cycle + 1;
        if (!rst) begin
            if (cdb.valid) begin
                if (exp_q.size() == 0) begin
                    $display("a result reached the bus with no instruction outstanding");
                    stop_run();
                end else begin
                    check_cdb(cdb, exp_q.pop_front());
                    void'(rob_q.pop_front());
                    void'(disp_q.pop_front());
                    retired = retired + 1;
                end
            end
            if (dispatch_valid) begin
                want = expect_cdb(dispatch);
                for (int b = 0; b < 4; b++) begin
                    if (want.wmask[b]) begin
                        ref_mem[want.addr[9:2]][8*b +: 8] = want.wdata[8*b +: 8];
                    end
                end
                exp_q.push_back(want);
                rob_q.push_back(dispatch.rob_num);
                disp_q.push_back(cycle);
            end
            if (commit_en && rob_q.size() != 0 && cycle >= disp_q[0] + 3) begin
                commit_valid <= 1'b1;
                commit_rob   <= rob_q[0];
            end else begin
                commit_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the run was still busy after %0d cycles", LIMIT_CYCLES);
        stop_run();
    end

    initial begin : stimulus
        logic [7:0] lane_b [4];
        int         start;
        lane_b = '{8'h81, 8'h12, 8'hf3, 8'h44};
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // word store and read back
        issue_op(make_store(lsq_pkg::f3_w, 12'h010), 32'h10, 32'hdeadbeef);
        issue_op(make_load(lsq_pkg::f3_w, 5'd3, 12'h020), '0, '0);
        drain();

        for (int i = 0; i < 4; i++) begin
            issue_op(make_store(lsq_pkg::f3_b, 12'(64 + i)), '0, {24'ha5a5a5, lane_b[i]});
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(make_load(lsq_pkg::f3_b, 5'd4, 12'(64 + i)), '0, '0);
            issue_op(make_load(lsq_pkg::f3_bu, 5'd5, 12'(64 + i)), '0, '0);
        end
        issue_op(make_store(lsq_pkg::f3_h, 12'h048), '0, 32'h1234_8001);
        issue_op(make_store(lsq_pkg::f3_h, 12'h04a), '0, 32'h5678_7ffe);
        for (int i = 0; i < 2; i++) begin
            issue_op(make_load(lsq_pkg::f3_h, 5'd6, 12'(72 + 2 * i)), '0, '0);
            issue_op(make_load(lsq_pkg::f3_hu, 5'd7, 12'(72 + 2 * i)), '0, '0);
        end
        drain();

        // ready entries held back by the rob
        commit_en = 1'b0;
        issue_op(make_store(lsq_pkg::f3_w, 12'h014), '0, 32'h0bad_cafe);
        issue_op(make_load(lsq_pkg::f3_h, 5'd8, 12'h016), '0, '0);
        issue_op(make_store(lsq_pkg::f3_b, 12'h017), '0, 32'h0000_0099);
        issue_op(make_load(lsq_pkg::f3_w, 5'd9, 12'h014), '0, '0);
        idle_cycles(1);
        repeat (20) begin
            @(negedge clk);
            if (cdb.valid) begin
                $display("a result reached the bus while commit was held low");
                stop_run();
            end
        end
        commit_en = 1'b1;
        drain();

        commit_en = 1'b0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            issue_op(make_load(lsq_pkg::f3_w, 5'(i), 12'(4 * i)), '0, '0);
        end
        idle_cycles(1);
        @(negedge clk);
        check_full(full, 1'b1);
        commit_en = 1'b1;
        start     = retired;
        while (retired == start) @(negedge clk);
        check_full(full, 1'b0);   // one slot freed
        drain();

        for (int n = 0; n < 300; n++) begin
            random_op();
        end
        drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
    parameter int QUEUE_DEPTH = 16,
    parameter int MEM_WORDS   = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  lsq_pkg::dispatch_t dispatch,
    input  logic               commit_valid,
    input  logic [5:0]         commit_rob,
    output logic               full,
    output lsq_pkg::cdb_t      cdb
);

    logic                enq_valid;
    lsq_pkg::lsq_entry_t enq_entry;
    logic [5:0]          enq_idx;
    logic                agu_valid;
    lsq_pkg::agu_req_t   agu_req;
    logic                addr_valid;
    lsq_pkg::agu_rsp_t   agu_rsp;
    logic                req_valid;
    lsq_pkg::mem_req_t   mem_req;
    logic                rsp_valid;
    logic [31:0]         rdata;
    logic                deq_valid;
    lsq_pkg::lsq_entry_t deq_entry;
    lsq_pkg::mem_req_t   deq_req;

    mem_decode i_decode (
        .clk, .rst, .dispatch_valid, .dispatch, .enq_idx,
        .enq_valid, .enq_entry, .agu_valid, .agu_req
    );

    agu i_agu (
        .clk, .rst, .agu_valid, .agu_req, .addr_valid, .agu_rsp
    );

    memory_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk, .rst, .enq_valid, .enq_entry, .addr_valid, .agu_rsp,
        .commit_valid, .commit_rob, .rsp_valid, .enq_idx, .full,
        .req_valid, .mem_req, .deq_valid, .deq_entry, .deq_req
    );

    data_ram #(.MEM_WORDS(MEM_WORDS)) i_ram (
        .clk, .rst, .req_valid, .mem_req, .rsp_valid, .rdata
    );

    mem_result i_result (
        .clk, .rst, .deq_valid, .deq_entry, .deq_req, .rdata, .cdb
    );

endmodule

// ==== design/mem_result.sv ====
`timescale 1ns/1ps

module mem_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                deq_valid,
    input  lsq_pkg::lsq_entry_t deq_entry,
    input  lsq_pkg::mem_req_t   deq_req,
    input  logic [31:0]         rdata,
    output lsq_pkg::cdb_t       cdb
);

    logic [1:0]    lane;
    logic [7:0]    byte_v;
    logic [15:0]   half_v;
    logic [31:0]   load_v;
    logic [31:0]   byte_en;
    lsq_pkg::cdb_t rec;

    assign lane   = deq_entry.addr[1:0];
    assign byte_v = rdata[8*lane +: 8];
    assign half_v = rdata[16*lane[1] +: 16];

    always_comb begin
        case (deq_entry.funct3)
            lsq_pkg::f3_b:  load_v = {{24{byte_v[7]}}, byte_v};
            lsq_pkg::f3_bu: load_v = {24'd0, byte_v};
            lsq_pkg::f3_h:  load_v = {{16{half_v[15]}}, half_v};
            lsq_pkg::f3_hu: load_v = {16'd0, half_v};
            default:        load_v = rdata;
        endcase
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byte_en[8*b +: 8] = {8{deq_req.wmask[b]}};
        end
        rec.valid   = 1'b1;
        rec.rob_idx = deq_entry.rob_num;
        rec.pd_s    = deq_entry.pd_s;
        rec.rd_s    = deq_entry.rd_s;
        rec.rd_v    = deq_entry.is_load ? load_v : 32'd0;
        rec.addr    = deq_req.addr;
        rec.rmask   = deq_req.rmask;
        rec.wmask   = deq_req.wmask;
        rec.wdata   = deq_req.wdata & byte_en;   // only the written lanes
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else if (deq_valid) begin
            cdb <= rec;
        end else begin
            cdb.valid <= 1'b0;
        end
    end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  lsq_pkg::mem_req_t mem_req,
    output logic              rsp_valid,
    output logic [31:0]       rdata
);

    localparam int WA_W = $clog2(MEM_WORDS);

    logic [31:0]     ram [MEM_WORDS];
    logic [WA_W-1:0] waddr;

    assign waddr = mem_req.addr[WA_W+1:2];   // word index

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata <= ram[waddr];
            for (int b = 0; b < 4; b++) begin
                if (mem_req.wmask[b]) begin
                    ram[waddr][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

endmodule

// ==== design/memory_queue.sv ====
`timescale 1ns/1ps

module memory_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                enq_valid,
    input  lsq_pkg::lsq_entry_t enq_entry,
    input  logic                addr_valid,
    input  lsq_pkg::agu_rsp_t   agu_rsp,
    input  logic                commit_valid,
    input  logic [5:0]          commit_rob,
    input  logic                rsp_valid,
    output logic [5:0]          enq_idx,
    output logic                full,
    output logic                req_valid,
    output lsq_pkg::mem_req_t   mem_req,
    output logic                deq_valid,
    output lsq_pkg::lsq_entry_t deq_entry,
    output lsq_pkg::mem_req_t   deq_req
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    lsq_pkg::lsq_entry_t slots [QUEUE_DEPTH];
    lsq_pkg::lsq_entry_t head_entry;

    logic [PTR_W:0] head;   // msb is the wrap bit
    logic [PTR_W:0] tail;
    logic           busy;   // request out and response pending
    logic [1:0]     lane;
    logic [3:0]     mask;

    assign enq_idx    = 6'(tail[PTR_W-1:0]);
    assign full       = (head[PTR_W-1:0] == tail[PTR_W-1:0]) && (head[PTR_W] != tail[PTR_W]);
    assign head_entry = slots[head[PTR_W-1:0]];
    assign lane       = head_entry.addr[1:0];

    // oldest entry may go once the rob retires it
    assign req_valid = head_entry.valid && head_entry.addr_ready && !busy &&
                       commit_valid && (head_entry.rob_num == commit_rob);

    always_comb begin
        case (head_entry.funct3[1:0])
            2'b00:   mask = 4'b0001 << lane;
            2'b01:   mask = 4'b0011 << lane;
            default: mask = 4'b1111;
        endcase
    end

    always_comb begin
        mem_req.addr  = {head_entry.addr[31:2], 2'b00};
        mem_req.rmask = head_entry.is_load ? mask : 4'b0000;
        mem_req.wmask = head_entry.is_load ? 4'b0000 : mask;
        if (head_entry.is_load) begin
            mem_req.wdata = '0;
        end else begin
            mem_req.wdata = head_entry.store_wdata << {lane, 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            busy <= 1'b0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            if (addr_valid) begin
                slots[agu_rsp.idx[PTR_W-1:0]].addr        <= agu_rsp.addr;
                slots[agu_rsp.idx[PTR_W-1:0]].store_wdata <= agu_rsp.store_wdata;
                slots[agu_rsp.idx[PTR_W-1:0]].addr_ready  <= 1'b1;
            end
            if (rsp_valid) begin
                slots[head[PTR_W-1:0]].valid <= 1'b0;
                head <= head + 1'b1;
            end
            if (enq_valid) begin
                slots[tail[PTR_W-1:0]] <= enq_entry;
                tail <= tail + 1'b1;
            end
            if (rsp_valid) begin
                busy <= 1'b0;
            end else if (req_valid) begin
                busy <= 1'b1;
            end
        end
    end

    // kept for the result stage
    always_ff @(posedge clk) begin
        if (req_valid) begin
            deq_req <= mem_req;
        end
    end

    assign deq_valid = rsp_valid;
    assign deq_entry = head_entry;

    a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
        enq_valid |-> !full)
        else $error("dispatch while queue full");

    a_wb_valid_slot: assert property (@(posedge clk) disable iff (rst)
        addr_valid |-> slots[agu_rsp.idx[PTR_W-1:0]].valid)
        else $error("address writeback to empty slot");

    a_rsp_after_req: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> busy)
        else $error("memory response without request");

endmodule

// ==== design/agu.sv ====
`timescale 1ns/1ps

module agu (
    input  logic              clk,
    input  logic              rst,
    input  logic              agu_valid,
    input  lsq_pkg::agu_req_t agu_req,
    output logic              addr_valid,
    output lsq_pkg::agu_rsp_t agu_rsp
);

    logic [31:0] sum;

    assign sum = agu_req.base + agu_req.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= agu_valid;   // one job per cycle without stall
        end
    end

    always_ff @(posedge clk) begin
        if (agu_valid) begin
            agu_rsp.addr        <= sum;
            agu_rsp.store_wdata <= agu_req.store_wdata;
            agu_rsp.idx         <= agu_req.idx;
        end
    end

endmodule

// ==== design/mem_decode.sv ====
`timescale 1ns/1ps

module mem_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  lsq_pkg::dispatch_t  dispatch,
    input  logic [5:0]          enq_idx,
    output logic                enq_valid,
    output lsq_pkg::lsq_entry_t enq_entry,
    output logic                agu_valid,
    output lsq_pkg::agu_req_t   agu_req
);

    logic [31:0] inst;
    logic [6:0]  opcode;
    logic        is_load;
    logic [31:0] imm;

    assign inst    = dispatch.inst;
    assign opcode  = inst[6:0];
    assign is_load = (opcode == lsq_pkg::op_load);

    always_comb begin
        if (is_load) begin
            imm = {{20{inst[31]}}, inst[31:20]};               // i-type
        end else begin
            imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};   // s-type
        end
    end

    always_comb begin
        enq_valid             = dispatch_valid;
        enq_entry.valid       = 1'b1;
        enq_entry.addr_ready  = 1'b0;
        enq_entry.is_load     = is_load;
        enq_entry.funct3      = inst[14:12];
        enq_entry.rd_s        = is_load ? inst[11:7] : 5'd0;   // stores write no register
        enq_entry.pd_s        = dispatch.pd_s;
        enq_entry.rob_num     = dispatch.rob_num;
        enq_entry.addr        = '0;
        enq_entry.store_wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            agu_valid <= 1'b0;
        end else begin
            agu_valid <= dispatch_valid;
        end
    end

    // job tagged with the slot the queue hands out this cycle
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            agu_req.base        <= dispatch.rs1_rdata;
            agu_req.imm         <= imm;
            agu_req.store_wdata <= dispatch.rs2_rdata;
            agu_req.idx         <= enq_idx;
        end
    end

    a_mem_only: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> (opcode == lsq_pkg::op_load || opcode == lsq_pkg::op_store))
        else $error("non-memory opcode dispatched");

endmodule

// ==== design/lsq_pkg.sv ====
package lsq_pkg;

    // rv32i major opcodes
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // width codes for loads and stores
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [5:0]  pd_s;
        logic [5:0]  rob_num;
    } dispatch_t;

    typedef struct packed {
        logic [31:0] base;
        logic [31:0] imm;          // already sign-extended
        logic [31:0] store_wdata;
        logic [5:0]  idx;
    } agu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] store_wdata;
        logic [5:0]  idx;
    } agu_rsp_t;

    typedef struct packed {
        logic        valid;
        logic        addr_ready;
        logic        is_load;
        logic [2:0]  funct3;
        logic [4:0]  rd_s;
        logic [5:0]  pd_s;
        logic [5:0]  rob_num;
        logic [31:0] addr;
        logic [31:0] store_wdata;
    } lsq_entry_t;

    typedef struct packed {
        logic [31:0] addr;         // word aligned
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [5:0]  rob_idx;
        logic [5:0]  pd_s;
        logic [4:0]  rd_s;
        logic [31:0] rd_v;
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } cdb_t;

endpackage
